//--- dv/tq_properties.sv
`timescale 1ns/1ns
`include "tq_config.svh"

module tq_properties import tq_pkg::*; (
    input logic      clk_i,
    input logic      arst_n_i,
    input logic      valid_i,
    input logic      level_valid_i,
    input coef_blk_t level_i,
    input logic      recon_valid_i,
    input res_blk_t  recon_i
);

    // details of the latest failure
    string fail_name;
    int    fail_exp;
    int    fail_act;
    int    fail_cnt = 0;

    int   dc_exp;
    int   rec_exp;
    logic lvl_flat;
    logic rec_flat;
    int   dc_act;
    int   ac_act;
    int   rec_act;
    logic rec_ok;

    assign dc_exp = tq_tb.lvl_exp;
    assign rec_exp = tq_tb.rec_exp;
    assign lvl_flat = tq_tb.lvl_flat;
    assign rec_flat = tq_tb.rec_flat;
    assign dc_act = int'(coef_t'(level_i[`TQ_COEF_W-1:0]));
    assign rec_ok = (recon_i == {`TQ_BLK_N{res_t'(rec_exp)}});

    // lowest nonzero ac level, and a sample off the flat value if there is one
    always_comb begin
        ac_act = 0;
        rec_act = int'(res_t'(recon_i[`TQ_RES_W-1:0]));
        for (int i = `TQ_BLK_N - 1; i > 0; i--) begin
            if (level_i[i*`TQ_COEF_W +: `TQ_COEF_W] != '0) begin
                ac_act = int'(coef_t'(level_i[i*`TQ_COEF_W +: `TQ_COEF_W]));
            end
            if (int'(res_t'(recon_i[i*`TQ_RES_W +: `TQ_RES_W])) != rec_exp) begin
                rec_act = int'(res_t'(recon_i[i*`TQ_RES_W +: `TQ_RES_W]));
            end
        end
    end

    task automatic note_fail(input string name, input int e, input int a);
        fail_name = name;
        fail_exp = e;
        fail_act = a;
        fail_cnt = fail_cnt + 1;
    endtask

    reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> (!level_valid_i && !recon_valid_i))
    else begin
        note_fail("reset quiet", 0, 1);
        $error("valid output high during reset");
    end

    level_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        level_valid_i == $past(valid_i, `TQ_QUANT_LAT))
    else begin
        note_fail("level latency", int'(!$sampled(level_valid_i)), int'($sampled(level_valid_i)));
        $error("level_valid_o out of step with valid_i");
    end

    recon_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        recon_valid_i == $past(valid_i, `TQ_RECON_LAT))
    else begin
        note_fail("recon latency", int'(!$sampled(recon_valid_i)), int'($sampled(recon_valid_i)));
        $error("recon_valid_o out of step with valid_i");
    end

    flat_dc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (level_valid_i && lvl_flat) |-> (dc_act == dc_exp))
    else begin
        note_fail("flat dc level", $sampled(dc_exp), $sampled(dc_act));
        $error("wrong dc level for a flat block");
    end

    flat_ac: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (level_valid_i && lvl_flat) |-> (level_i[`TQ_BLK_N*`TQ_COEF_W-1:`TQ_COEF_W] == '0))
    else begin
        note_fail("flat ac levels", 0, $sampled(ac_act));
        $error("nonzero ac level for a flat block");
    end

    flat_recon: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (recon_valid_i && rec_flat) |-> rec_ok)
    else begin
        note_fail("flat recon", $sampled(rec_exp), $sampled(rec_act));
        $error("wrong reconstruction for a flat block");
    end

endmodule

//--- dv/tq_tb.sv
`timescale 1ns/1ns
`include "tq_config.svh"

module tq_tb import tq_pkg::*; ();

    logic      clk;
    logic      arst_n;
    logic      valid;
    res_blk_t  blk;
    qp_t       qp;
    logic      level_valid;
    coef_blk_t level;
    logic      recon_valid;
    res_blk_t  recon;

    // expectation for the block now on each output, read by the bound checks
    int lvl_exp;
    bit lvl_flat;
    int rec_exp;
    bit rec_flat;
    int lvl_q [$];
    bit lvl_flat_q [$];
    int rec_q [$];
    bit rec_flat_q [$];
    int seed;

    tq_top uut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .valid_i       (valid),
        .blk_i         (blk),
        .qp_i          (qp),
        .level_valid_o (level_valid),
        .level_o       (level),
        .recon_valid_o (recon_valid),
        .recon_o       (recon)
    );

    bind tq_top tq_properties u_props (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .level_valid_i (level_valid_o),
        .level_i       (level_o),
        .recon_valid_i (recon_valid_o),
        .recon_i       (recon_o)
    );

    always #50 clk = ~clk;

    // dc level of a flat block: |16r| * MF, shift, round half up, sign back
    function automatic int flat_level(input int r, input int qp_v);
        int mf;
        int mag;
        case (qp_v % 6)
            0: mf = 13107;
            1: mf = 11916;
            2: mf = 10082;
            3: mf = 9362;
            4: mf = 8192;
            default: mf = 7282;
        endcase
        mag = ((16 * ((r < 0) ? -r : r)) * mf) >> (14 + qp_v / 6);
        mag = (mag + 1) >> 1;
        return (r < 0) ? -mag : mag;
    endfunction

    // only the dc term survives, so every sample gets the same value
    function automatic int flat_recon(input int lvl, input int qp_v);
        int v;
        int s;
        case (qp_v % 6)
            0: v = 10;
            1: v = 11;
            2: v = 13;
            3: v = 14;
            4: v = 16;
            default: v = 18;
        endcase
        s = lvl * v * (1 << (qp_v / 6));
        s = (s > 32767) ? 32767 : ((s < -32768) ? -32768 : s);
        s = (s + 32) >>> 6;
        return (s > 255) ? 255 : ((s < -255) ? -255 : s);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic drive_block(input res_blk_t b, input int qp_v, input bit flat, input int r);
        int l;
        @(negedge clk);
        valid = 1'b1;
        blk = b;
        qp = qp_t'(qp_v);
        l = flat_level(r, qp_v);
        lvl_q.push_back(l);
        lvl_flat_q.push_back(flat);
        rec_q.push_back(flat_recon(l, qp_v));
        rec_flat_q.push_back(flat);
    endtask

    task automatic send_flat(input int r, input int qp_v);
        res_blk_t b;
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            b[i*`TQ_RES_W +: `TQ_RES_W] = res_t'(r);
        end
        drive_block(b, qp_v, 1'b1, r);
    endtask

    task automatic send_random(input int qp_v);
        res_blk_t b;
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            b[i*`TQ_RES_W +: `TQ_RES_W] = res_t'($random(seed) % 256);
        end
        drive_block(b, qp_v, 1'b0, 0);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic await_valid(input bit use_recon, input int max_cycles);
        int n;
        for (n = 0; n < max_cycles && !(use_recon ? recon_valid : level_valid); n++) begin
            idle_cycle();
        end
        if (!(use_recon ? recon_valid : level_valid)) begin
            abort_run(use_recon ? "timeout waiting for recon_valid_o"
                                : "timeout waiting for level_valid_o");
        end
    endtask

    task automatic drain(input int max_cycles);
        int n;
        for (n = 0; n < max_cycles && (lvl_q.size() + rec_q.size()) != 0; n++) begin
            idle_cycle();
        end
        if ((lvl_q.size() + rec_q.size()) != 0) begin
            abort_run("timeout waiting for the pipeline to drain");
        end
    endtask

    // outputs are stable here, half a cycle before the checks sample them
    always @(negedge clk) begin
        if (uut.u_props.fail_cnt != 0) begin
            abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                                uut.u_props.fail_name, uut.u_props.fail_exp,
                                uut.u_props.fail_act));
        end else begin
            if (level_valid && lvl_q.size() != 0) begin
                lvl_exp = lvl_q.pop_front();
                lvl_flat = lvl_flat_q.pop_front();
            end
            if (recon_valid && rec_q.size() != 0) begin
                rec_exp = rec_q.pop_front();
                rec_flat = rec_flat_q.pop_front();
            end
        end
    end

    initial begin
        int q;
        int sel;
        clk = 1'b0;
        arst_n = 1'b0;
        valid = 1'b0;
        blk = '0;
        qp = '0;
        lvl_exp = 0;
        lvl_flat = 1'b0;
        rec_exp = 0;
        rec_flat = 1'b0;
        seed = 99432;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        idle_cycle();
        idle_cycle();
        // lone zero block, followed through both outputs
        send_flat(0, 28);
        await_valid(1'b0, 8);
        await_valid(1'b1, 8);
        send_flat(0, 0);
        send_flat(0, `TQ_QP_MAX);
        // every qp%6 row back to back, then the middle and top of the qp range
        for (int m = 0; m < 6; m++) begin
            send_flat($random(seed) % 256, m);
        end
        send_flat(-200, 27);
        send_flat(255, `TQ_QP_MAX);
        send_flat(-255, 0);
        drain(20);
        // random mix, with the odd gap
        for (int k = 0; k < 80; k++) begin
            q = {$random(seed)} % 52;
            sel = {$random(seed)} % 8;
            if (sel == 0) begin
                idle_cycle();
            end else if (sel < 3) begin
                send_random(q);
            end else begin
                send_flat($random(seed) % 256, q);
            end
        end
        drain(20);
        idle_cycle();
        if (uut.u_props.fail_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("assertion failures were recorded");
        end
    end

endmodule

//--- hdl/tq_dct_4x4.sv
`timescale 1ns/1ns
`include "tq_config.svh"

module tq_dct_4x4 import tq_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  res_blk_t  blk_i,
    input  qp_t       qp_i,
    output logic      valid_o,
    output coef_blk_t coef_o,
    output qpdiv6_t   qpdiv6_o,
    output qpmod6_t   qpmod6_o
);

    // both passes stay within 15 bits for 9-bit residuals
    coef_t     x_w [`TQ_BLK_N];
    coef_t     h_w [`TQ_BLK_N];
    coef_t     y_w [`TQ_BLK_N];
    coef_blk_t coef_w;
    qpdiv6_t   qpdiv6_w;
    qpmod6_t   qpmod6_w;

    // one 4-point forward butterfly
    function automatic void fwd_bfly(input coef_t a0, a1, a2, a3,
                                     output coef_t b0, b1, b2, b3);
        coef_t s03;
        coef_t d03;
        coef_t s12;
        coef_t d12;
        s03 = a0 + a3;
        d03 = a0 - a3;
        s12 = a1 + a2;
        d12 = a1 - a2;
        b0 = s03 + s12;
        b1 = (d03 <<< 1) + d12;
        b2 = s03 - s12;
        b3 = d03 - (d12 <<< 1);
    endfunction

    always_comb begin
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            x_w[i] = coef_t'(res_t'(blk_i[i*`TQ_RES_W +: `TQ_RES_W]));
        end
        // rows first
        for (int r = 0; r < 4; r++) begin
            fwd_bfly(x_w[4*r], x_w[4*r+1], x_w[4*r+2], x_w[4*r+3],
                     h_w[4*r], h_w[4*r+1], h_w[4*r+2], h_w[4*r+3]);
        end
        // then columns
        for (int c = 0; c < 4; c++) begin
            fwd_bfly(h_w[c], h_w[4+c], h_w[8+c], h_w[12+c],
                     y_w[c], y_w[4+c], y_w[8+c], y_w[12+c]);
        end
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            coef_w[i*`TQ_COEF_W +: `TQ_COEF_W] = y_w[i];
        end
    end

    // qp split, constant divide maps to a small table
    assign qpdiv6_w = qpdiv6_t'(qp_i / 6'd6);
    assign qpmod6_w = qpmod6_t'(qp_i % 6'd6);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            coef_o <= '0;
            qpdiv6_o <= '0;
            qpmod6_o <= '0;
        end else begin
            valid_o <= valid_i;
            coef_o <= coef_w;
            qpdiv6_o <= qpdiv6_w;
            qpmod6_o <= qpmod6_w;
        end
    end

endmodule

//--- hdl/tq_dequant_4x4.sv
`timescale 1ns/1ns
`include "tq_config.svh"

module tq_dequant_4x4 import tq_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  coef_blk_t level_i,
    input  qpdiv6_t   qpdiv6_i,
    input  qpmod6_t   qpmod6_i,
    output logic      valid_o,
    output dq_blk_t   dq_o
);

    localparam int DQ_MAX = (1 << (`TQ_DQ_W - 1)) - 1;
    localparam int DQ_MIN = -(1 << (`TQ_DQ_W - 1));

    logic [4:0] v_w [`TQ_BLK_N];
    int         p_w [`TQ_BLK_N];
    int         s_w [`TQ_BLK_N];
    dq_blk_t    dq_w;

    // rescale factor by qp%6 and position class
    function automatic logic [4:0] v_lookup(input qpmod6_t m, input pos_cls_t cls);
        logic [4:0] ee;
        logic [4:0] oo;
        logic [4:0] mix;
        case (m)
            3'd0: begin ee = 5'd10; oo = 5'd16; mix = 5'd13; end
            3'd1: begin ee = 5'd11; oo = 5'd18; mix = 5'd14; end
            3'd2: begin ee = 5'd13; oo = 5'd20; mix = 5'd16; end
            3'd3: begin ee = 5'd14; oo = 5'd23; mix = 5'd18; end
            3'd4: begin ee = 5'd16; oo = 5'd25; mix = 5'd20; end
            3'd5: begin ee = 5'd18; oo = 5'd29; mix = 5'd23; end
            default: begin ee = 5'd0; oo = 5'd0; mix = 5'd0; end
        endcase
        if (cls == POS_EE) begin
            return ee;
        end
        if (cls == POS_OO) begin
            return oo;
        end
        return mix;
    endfunction

    always_comb begin
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            v_w[i] = v_lookup(qpmod6_i, pos_class(i));
            p_w[i] = int'(coef_t'(level_i[i*`TQ_COEF_W +: `TQ_COEF_W])) * int'(v_w[i]);
            // at most 2^28 in magnitude, no overflow in 32 bits
            s_w[i] = p_w[i] <<< qpdiv6_i;
            if (s_w[i] > DQ_MAX) begin
                dq_w[i*`TQ_DQ_W +: `TQ_DQ_W] = dq_t'(DQ_MAX);
            end else if (s_w[i] < DQ_MIN) begin
                dq_w[i*`TQ_DQ_W +: `TQ_DQ_W] = dq_t'(DQ_MIN);
            end else begin
                dq_w[i*`TQ_DQ_W +: `TQ_DQ_W] = dq_t'(s_w[i]);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            dq_o <= '0;
        end else begin
            valid_o <= valid_i;
            dq_o <= dq_w;
        end
    end

endmodule

//--- hdl/tq_idct_4x4.sv
`timescale 1ns/1ns
`include "tq_config.svh"

module tq_idct_4x4 import tq_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  dq_blk_t  dq_i,
    output logic     valid_o,
    output res_blk_t recon_o
);

    localparam int REC_MAX = (1 << (`TQ_RES_W - 1)) - 1;
    localparam int REC_MIN = -REC_MAX;

    int       d_w [`TQ_BLK_N];
    int       g_w [`TQ_BLK_N];
    int       f_w [`TQ_BLK_N];
    int       v_w [`TQ_BLK_N];
    res_blk_t recon_w;

    // inverse butterfly, odd inputs enter at half weight
    function automatic void inv_bfly(input int a0, a1, a2, a3,
                                     output int b0, b1, b2, b3);
        int e0;
        int e1;
        int e2;
        int e3;
        e0 = a0 + a2;
        e1 = a0 - a2;
        e2 = (a1 >>> 1) - a3;
        e3 = a1 + (a3 >>> 1);
        b0 = e0 + e3;
        b1 = e1 + e2;
        b2 = e1 - e2;
        b3 = e0 - e3;
    endfunction

    always_comb begin
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            d_w[i] = int'(dq_t'(dq_i[i*`TQ_DQ_W +: `TQ_DQ_W]));
        end
        for (int r = 0; r < 4; r++) begin
            inv_bfly(d_w[4*r], d_w[4*r+1], d_w[4*r+2], d_w[4*r+3],
                     g_w[4*r], g_w[4*r+1], g_w[4*r+2], g_w[4*r+3]);
        end
        for (int c = 0; c < 4; c++) begin
            inv_bfly(g_w[c], g_w[4+c], g_w[8+c], g_w[12+c],
                     f_w[c], f_w[4+c], f_w[8+c], f_w[12+c]);
        end
        // divide by 64 with rounding, then clip to the residual range
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            v_w[i] = (f_w[i] + 32) >>> 6;
            if (v_w[i] > REC_MAX) begin
                v_w[i] = REC_MAX;
            end else if (v_w[i] < REC_MIN) begin
                v_w[i] = REC_MIN;
            end
            recon_w[i*`TQ_RES_W +: `TQ_RES_W] = res_t'(v_w[i]);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            recon_o <= '0;
        end else begin
            valid_o <= valid_i;
            recon_o <= recon_w;
        end
    end

endmodule

//--- hdl/tq_pkg.sv
`include "tq_config.svh"

package tq_pkg;

    typedef logic [`TQ_QP_W-1:0] qp_t;
    typedef logic [`TQ_QPDIV6_W-1:0] qpdiv6_t;
    typedef logic [`TQ_QPMOD6_W-1:0] qpmod6_t;

    // single samples
    typedef logic signed [`TQ_RES_W-1:0] res_t;
    typedef logic signed [`TQ_COEF_W-1:0] coef_t;
    typedef logic signed [`TQ_DQ_W-1:0] dq_t;

    // whole blocks, sample (r,c) at index 4r+c, index 0 in the low bits
    typedef logic [`TQ_BLK_N*`TQ_RES_W-1:0] res_blk_t;
    typedef logic [`TQ_BLK_N*`TQ_COEF_W-1:0] coef_blk_t;
    typedef logic [`TQ_BLK_N*`TQ_DQ_W-1:0] dq_blk_t;

    // scaling class of a coefficient position
    typedef logic [1:0] pos_cls_t;
    localparam pos_cls_t POS_EE = 2'd0;
    localparam pos_cls_t POS_OO = 2'd1;
    localparam pos_cls_t POS_MIX = 2'd2;

    // bit 2 of the index is the row lsb, bit 0 the column lsb
    function automatic pos_cls_t pos_class(input int idx);
        logic row_odd;
        logic col_odd;
        row_odd = idx[2];
        col_odd = idx[0];
        if (!row_odd && !col_odd) begin
            return POS_EE;
        end
        if (row_odd && col_odd) begin
            return POS_OO;
        end
        return POS_MIX;
    endfunction

endpackage

//--- hdl/tq_quant_4x4.sv
`timescale 1ns/1ns
`include "tq_config.svh"

module tq_quant_4x4 import tq_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  coef_blk_t coef_i,
    input  qpdiv6_t   qpdiv6_i,
    input  qpmod6_t   qpmod6_i,
    output logic      valid_o,
    output coef_blk_t level_o,
    output qpdiv6_t   qpdiv6_o,
    output qpmod6_t   qpmod6_o
);

    coef_t                  c_w    [`TQ_BLK_N];
    logic [`TQ_COEF_W-1:0]  abs_w  [`TQ_BLK_N];
    logic [13:0]            mf_w   [`TQ_BLK_N];
    logic [31:0]            prod_w [`TQ_BLK_N];
    logic [31:0]            r_w    [`TQ_BLK_N];
    logic [31:0]            q_w    [`TQ_BLK_N];
    coef_t                  mag_w  [`TQ_BLK_N];
    logic [4:0]             shamt_w;
    coef_blk_t              level_w;

    // multiplication factor by qp%6 and position class
    function automatic logic [13:0] mf_lookup(input qpmod6_t m, input pos_cls_t cls);
        logic [13:0] ee;
        logic [13:0] oo;
        logic [13:0] mix;
        case (m)
            3'd0: begin ee = 14'd13107; oo = 14'd5243; mix = 14'd8066; end
            3'd1: begin ee = 14'd11916; oo = 14'd4660; mix = 14'd7490; end
            3'd2: begin ee = 14'd10082; oo = 14'd4194; mix = 14'd6554; end
            3'd3: begin ee = 14'd9362;  oo = 14'd3647; mix = 14'd5825; end
            3'd4: begin ee = 14'd8192;  oo = 14'd3355; mix = 14'd5243; end
            3'd5: begin ee = 14'd7282;  oo = 14'd2893; mix = 14'd4559; end
            default: begin ee = 14'd0; oo = 14'd0; mix = 14'd0; end
        endcase
        if (cls == POS_EE) begin
            return ee;
        end
        if (cls == POS_OO) begin
            return oo;
        end
        return mix;
    endfunction

    // qbits is 15 + qp/6, one bit less here so the lsb can round
    assign shamt_w = 5'(qpdiv6_i) + 5'd14;

    always_comb begin
        for (int i = 0; i < `TQ_BLK_N; i++) begin
            c_w[i] = coef_t'(coef_i[i*`TQ_COEF_W +: `TQ_COEF_W]);
            abs_w[i] = c_w[i][`TQ_COEF_W-1] ? -c_w[i] : c_w[i];
            mf_w[i] = mf_lookup(qpmod6_i, pos_class(i));
            prod_w[i] = 32'(abs_w[i]) * 32'(mf_w[i]);
            r_w[i] = prod_w[i] >> shamt_w;
            // round half up on the magnitude
            q_w[i] = (r_w[i] + 32'd1) >> 1;
            mag_w[i] = coef_t'(q_w[i][`TQ_COEF_W-1:0]);
            level_w[i*`TQ_COEF_W +: `TQ_COEF_W] = c_w[i][`TQ_COEF_W-1] ? -mag_w[i] : mag_w[i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            level_o <= '0;
            qpdiv6_o <= '0;
            qpmod6_o <= '0;
        end else begin
            valid_o <= valid_i;
            level_o <= level_w;
            qpdiv6_o <= qpdiv6_i;
            qpmod6_o <= qpmod6_i;
        end
    end

endmodule

//--- hdl/tq_top.sv
`timescale 1ns/1ns

module tq_top import tq_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  res_blk_t  blk_i,
    input  qp_t       qp_i,
    output logic      level_valid_o,
    output coef_blk_t level_o,
    output logic      recon_valid_o,
    output res_blk_t  recon_o
);

    // forward transform to quantizer
    logic      dct_valid;
    coef_blk_t dct_coef;
    qpdiv6_t   dct_qpdiv6;
    qpmod6_t   dct_qpmod6;

    // quantizer to dequantizer, levels leave the top here too
    qpdiv6_t   quant_qpdiv6;
    qpmod6_t   quant_qpmod6;

    // dequantizer to inverse transform
    logic      dq_valid;
    dq_blk_t   dq_blk;

    tq_dct_4x4 u_dct (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .blk_i    (blk_i),
        .qp_i     (qp_i),
        .valid_o  (dct_valid),
        .coef_o   (dct_coef),
        .qpdiv6_o (dct_qpdiv6),
        .qpmod6_o (dct_qpmod6)
    );

    tq_quant_4x4 u_quant (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (dct_valid),
        .coef_i   (dct_coef),
        .qpdiv6_i (dct_qpdiv6),
        .qpmod6_i (dct_qpmod6),
        .valid_o  (level_valid_o),
        .level_o  (level_o),
        .qpdiv6_o (quant_qpdiv6),
        .qpmod6_o (quant_qpmod6)
    );

    tq_dequant_4x4 u_dequant (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (level_valid_o),
        .level_i  (level_o),
        .qpdiv6_i (quant_qpdiv6),
        .qpmod6_i (quant_qpmod6),
        .valid_o  (dq_valid),
        .dq_o     (dq_blk)
    );

    tq_idct_4x4 u_idct (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (dq_valid),
        .dq_i     (dq_blk),
        .valid_o  (recon_valid_o),
        .recon_o  (recon_o)
    );

endmodule

//--- include/tq_config.svh
`ifndef TQ_CONFIG_SVH
`define TQ_CONFIG_SVH

// sample widths, all two's complement
`define TQ_RES_W 9
`define TQ_COEF_W 15
`define TQ_DQ_W 16

// qp fields
`define TQ_QP_W 6
`define TQ_QPDIV6_W 4
`define TQ_QPMOD6_W 3
`define TQ_QP_MAX 51

// samples per 4x4 block
`define TQ_BLK_N 16

// pipeline depth in cycles
`define TQ_STAGE_LAT 1
// residual in to levels out
`define TQ_QUANT_LAT 2
// residual in to reconstruction out
`define TQ_RECON_LAT 4

`endif

//--- project.f
+incdir+include
hdl/tq_pkg.sv
hdl/tq_dct_4x4.sv
hdl/tq_quant_4x4.sv
hdl/tq_dequant_4x4.sv
hdl/tq_idct_4x4.sv
hdl/tq_top.sv
dv/tq_properties.sv
dv/tq_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 --top-module tq_tb -f project.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# the testbench ends every failing run itself, so assertion errors must not stop it first
./obj_dir/Vtq_tb +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
echo "simulation finished cleanly"
exit 0
